//--- exeIsaPkg.sv
package exeIsaPkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // Operand and result width
    localparam int dataWidth = 32;

    // Register number width
    // Register zero reads as the supplied operand and is never forwarded
    localparam int regIndexWidth = 5;

    // Width of the operation code carried from decode
    localparam int aluOpWidth = 6;

    // Width of the immediate shift amount and of the variable shift count
    localparam int shiftWidth = 5;

    //////////////////////////////
    // Operation codes
    //////////////////////////////

    // Code zero is left unused so an all-zero bubble yields result zero

    // Wrapping add and subtract
    localparam logic [aluOpWidth-1:0] opAdd   = 6'h01;
    localparam logic [aluOpWidth-1:0] opSub   = 6'h02;

    // Bitwise logic
    localparam logic [aluOpWidth-1:0] opAnd   = 6'h04;
    localparam logic [aluOpWidth-1:0] opOr    = 6'h05;
    localparam logic [aluOpWidth-1:0] opXor   = 6'h06;
    localparam logic [aluOpWidth-1:0] opNor   = 6'h07;

    // Set on less than
    localparam logic [aluOpWidth-1:0] opSlt   = 6'h08;
    localparam logic [aluOpWidth-1:0] opSltu  = 6'h09;

    // Shifts by the immediate shift amount
    localparam logic [aluOpWidth-1:0] opSll   = 6'h10;
    localparam logic [aluOpWidth-1:0] opSrl   = 6'h11;
    localparam logic [aluOpWidth-1:0] opSra   = 6'h12;

    // Shifts by the low bits of operand A
    localparam logic [aluOpWidth-1:0] opSllv  = 6'h14;
    localparam logic [aluOpWidth-1:0] opSrlv  = 6'h15;
    localparam logic [aluOpWidth-1:0] opSrav  = 6'h16;

    // Load upper immediate
    localparam logic [aluOpWidth-1:0] opLui   = 6'h18;

    // HI/LO writes and reads
    localparam logic [aluOpWidth-1:0] opMult  = 6'h20;
    localparam logic [aluOpWidth-1:0] opMultu = 6'h21;
    localparam logic [aluOpWidth-1:0] opMthi  = 6'h22;
    localparam logic [aluOpWidth-1:0] opMtlo  = 6'h23;
    localparam logic [aluOpWidth-1:0] opMfhi  = 6'h24;
    localparam logic [aluOpWidth-1:0] opMflo  = 6'h25;

endpackage

//--- exePipePkg.sv
package exePipePkg;

    //////////////////////////////
    // Decode to execute
    //////////////////////////////

    // One issued instruction
    // A bubble has all control bits low
    typedef struct packed {
        // Debug tags only
        logic [31:0]                            instr;
        logic [31:0]                            pc;
        // First source register and its value as read in decode
        logic [exeIsaPkg::regIndexWidth-1:0]    regA;
        logic [exeIsaPkg::dataWidth-1:0]        operandA;
        // Second source register and its value
        logic [exeIsaPkg::regIndexWidth-1:0]    regB;
        logic [exeIsaPkg::dataWidth-1:0]        operandB;
        // Destination, also the store source for memory writes
        logic [exeIsaPkg::regIndexWidth-1:0]    writeReg;
        logic [exeIsaPkg::dataWidth-1:0]        storeData;
        logic                                   regWrite;
        logic                                   memRead;
        logic                                   memWrite;
        logic [exeIsaPkg::aluOpWidth-1:0]       aluOp;
        logic [exeIsaPkg::shiftWidth-1:0]       shiftAmount;
        // Prediction state and redirect carried for later stages
        logic                                   branchPrediction;
        logic [1:0]                             branchPredictions;
        logic                                   requestAltPc;
        logic [31:0]                            altPc;
    } exeIssue;

    //////////////////////////////
    // Execute to memory
    //////////////////////////////

    typedef struct packed {
        logic [31:0]                            instr;
        logic [31:0]                            pc;
        // Combined ALU or move-from result
        logic [exeIsaPkg::dataWidth-1:0]        result;
        logic [exeIsaPkg::regIndexWidth-1:0]    writeReg;
        // Store value after forwarding
        logic [exeIsaPkg::dataWidth-1:0]        storeData;
        logic                                   regWrite;
        logic                                   memRead;
        logic                                   memWrite;
        // Memory stage uses the code to pick the access size
        logic [exeIsaPkg::aluOpWidth-1:0]       aluOp;
        logic                                   branchPrediction;
        logic [1:0]                             branchPredictions;
        logic                                   requestAltPc;
        logic [31:0]                            altPc;
    } exeRetire;

    // One forwarding source
    typedef struct packed {
        logic [exeIsaPkg::regIndexWidth-1:0]    regNum;
        logic [exeIsaPkg::dataWidth-1:0]        data;
        logic                                   valid;
    } regBypass;

endpackage

//--- operandBypass.sv
module operandBypass (
    // Register whose newest value is wanted
    input  logic [exeIsaPkg::regIndexWidth-1:0] lookupReg,
    // Value read in decode, used when nothing newer is in flight
    input  logic [exeIsaPkg::dataWidth-1:0]     suppliedValue,
    // Result held in the stage's own retire register
    input  exePipePkg::regBypass                ownBypass,
    // Write-back value offered by the memory stage
    input  exePipePkg::regBypass                memBypass,
    output logic [exeIsaPkg::dataWidth-1:0]     resolvedValue
);

    //////////////////////////////
    // Match detection
    //////////////////////////////

    // Register zero is never forwarded
    logic lookupNonZero;

    // Per-source hit flags
    logic ownHit;
    logic memHit;

    assign lookupNonZero = (lookupReg != '0);

    // Own result is one instruction newer than the memory stage value
    assign ownHit = lookupNonZero
                 && ownBypass.valid
                 && (ownBypass.regNum == lookupReg);

    assign memHit = lookupNonZero
                 && memBypass.valid
                 && (memBypass.regNum == lookupReg);

    //////////////////////////////
    // Value selection
    //////////////////////////////

    // Priority order
    // own result first, then memory stage, then the decode value
    always_comb begin
        if (ownHit) begin
            resolvedValue = ownBypass.data;
        end else if (memHit) begin
            // Only reached when the own source misses
            resolvedValue = memBypass.data;
        end else begin
            resolvedValue = suppliedValue;
        end
    end

endmodule

//--- integerAlu.sv
module integerAlu (
    input  logic [exeIsaPkg::aluOpWidth-1:0] aluOp,
    // Operands after forwarding
    input  logic [exeIsaPkg::dataWidth-1:0]  operandA,
    input  logic [exeIsaPkg::dataWidth-1:0]  operandB,
    // Immediate shift amount from the instruction
    input  logic [exeIsaPkg::shiftWidth-1:0] shiftAmount,
    output logic [exeIsaPkg::dataWidth-1:0]  aluResult
);

    //////////////////////////////
    // Shared terms
    //////////////////////////////

    // Variable shift count taken from the low bits of A
    logic [exeIsaPkg::shiftWidth-1:0] varShift;

    // Compare outcomes
    logic lessSigned;
    logic lessUnsigned;

    // Wrapping sum and difference
    logic [exeIsaPkg::dataWidth-1:0] sum;
    logic [exeIsaPkg::dataWidth-1:0] difference;

    assign varShift = operandA[exeIsaPkg::shiftWidth-1:0];

    assign lessSigned   = ($signed(operandA) < $signed(operandB));
    assign lessUnsigned = (operandA < operandB);

    // No overflow detection in this stage
    assign sum        = operandA + operandB;
    assign difference = operandA - operandB;

    //////////////////////////////
    // Operation decode
    //////////////////////////////

    always_comb begin
        case (aluOp)
            exeIsaPkg::opAdd:  aluResult = sum;
            exeIsaPkg::opSub:  aluResult = difference;

            // Bitwise logic
            exeIsaPkg::opAnd:  aluResult = operandA & operandB;
            exeIsaPkg::opOr:   aluResult = operandA | operandB;
            exeIsaPkg::opXor:  aluResult = operandA ^ operandB;
            exeIsaPkg::opNor:  aluResult = ~(operandA | operandB);

            // Compare result is zero-extended to a full word
            exeIsaPkg::opSlt: begin
                aluResult = {{(exeIsaPkg::dataWidth-1){1'b0}}, lessSigned};
            end
            exeIsaPkg::opSltu: begin
                aluResult = {{(exeIsaPkg::dataWidth-1){1'b0}}, lessUnsigned};
            end

            // Immediate shifts act on B
            exeIsaPkg::opSll:  aluResult = operandB << shiftAmount;
            exeIsaPkg::opSrl:  aluResult = operandB >> shiftAmount;
            exeIsaPkg::opSra:  aluResult = $signed(operandB) >>> shiftAmount;

            // Variable shifts also act on B
            exeIsaPkg::opSllv: aluResult = operandB << varShift;
            exeIsaPkg::opSrlv: aluResult = operandB >> varShift;
            exeIsaPkg::opSrav: aluResult = $signed(operandB) >>> varShift;

            // Low half of B moves to the upper half
            exeIsaPkg::opLui: begin
                aluResult = {operandB[exeIsaPkg::dataWidth/2-1:0],
                             {(exeIsaPkg::dataWidth/2){1'b0}}};
            end

            // Multiply, move and unknown codes give zero here
            default:           aluResult = '0;
        endcase
    end

endmodule

//--- hiLoUnit.sv
module hiLoUnit (
    input  logic                             CLK,
    input  logic                             RESET,
    // Blocks the HI/LO write of the flushed instruction
    input  logic                             FLUSH,
    input  logic [exeIsaPkg::aluOpWidth-1:0] aluOp,
    input  logic [exeIsaPkg::dataWidth-1:0]  operandA,
    input  logic [exeIsaPkg::dataWidth-1:0]  operandB,
    // HI or LO as read by a move-from
    output logic [exeIsaPkg::dataWidth-1:0]  moveResult
);

    //////////////////////////////
    // State and products
    //////////////////////////////

    logic [exeIsaPkg::dataWidth-1:0] hi;
    logic [exeIsaPkg::dataWidth-1:0] lo;

    // Full double-width products
    logic signed [2*exeIsaPkg::dataWidth-1:0] signedProduct;
    logic        [2*exeIsaPkg::dataWidth-1:0] unsignedProduct;

    // Next values and write strobes
    logic [exeIsaPkg::dataWidth-1:0] hiNext;
    logic [exeIsaPkg::dataWidth-1:0] loNext;
    logic                            hiWrite;
    logic                            loWrite;

    // Operands are sign-extended to the product width
    assign signedProduct   = $signed(operandA) * $signed(operandB);
    assign unsignedProduct = operandA * operandB;

    //////////////////////////////
    // Write decode
    //////////////////////////////

    always_comb begin
        hiNext  = hi;
        loNext  = lo;
        hiWrite = 1'b0;
        loWrite = 1'b0;
        case (aluOp)
            exeIsaPkg::opMult: begin
                {hiNext, loNext} = signedProduct;
                hiWrite = 1'b1;
                loWrite = 1'b1;
            end
            exeIsaPkg::opMultu: begin
                {hiNext, loNext} = unsignedProduct;
                hiWrite = 1'b1;
                loWrite = 1'b1;
            end
            // Move-to copies A
            exeIsaPkg::opMthi: begin
                hiNext  = operandA;
                hiWrite = 1'b1;
            end
            exeIsaPkg::opMtlo: begin
                loNext  = operandA;
                loWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Update at the end of the issue cycle
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            hi <= '0;
            lo <= '0;
        end else if (!FLUSH) begin
            if (hiWrite) begin
                hi <= hiNext;
            end
            if (loWrite) begin
                lo <= loNext;
            end
        end
    end

    // Read path gives LO unless the code asks for HI
    assign moveResult = (aluOp == exeIsaPkg::opMfhi) ? hi : lo;

endmodule

//--- exeStage.sv
module exeStage (
    input  logic                 CLK,
    input  logic                 RESET,
    // Clears the retire register at the next edge
    input  logic                 FLUSH,
    input  exePipePkg::exeIssue  issue,
    // Write-back value from the memory stage
    input  exePipePkg::regBypass memBypass,
    output exePipePkg::exeRetire retire,
    // Combinational result offered to decode
    output exePipePkg::regBypass earlyBypass
);

    //////////////////////////////
    // Operand forwarding
    //////////////////////////////

    // Own result as a forwarding source
    exePipePkg::regBypass ownBypass;

    logic [exeIsaPkg::dataWidth-1:0] resolvedA;
    logic [exeIsaPkg::dataWidth-1:0] resolvedB;
    logic [exeIsaPkg::dataWidth-1:0] resolvedStore;

    // Unit outputs and their combination
    logic [exeIsaPkg::dataWidth-1:0] aluResult;
    logic [exeIsaPkg::dataWidth-1:0] moveResult;
    logic [exeIsaPkg::dataWidth-1:0] combinedResult;
    logic                            isMoveFrom;

    // Bundle loaded into the retire register
    exePipePkg::exeRetire nextRetire;

    // Loads and stores produce an address here, not register data
    always_comb begin
        ownBypass.regNum = retire.writeReg;
        ownBypass.data   = retire.result;
        ownBypass.valid  = retire.regWrite && !(retire.memRead || retire.memWrite);
    end

    operandBypass bypassA (
        .lookupReg    (issue.regA),
        .suppliedValue(issue.operandA),
        .ownBypass    (ownBypass),
        .memBypass    (memBypass),
        .resolvedValue(resolvedA)
    );

    operandBypass bypassB (
        .lookupReg    (issue.regB),
        .suppliedValue(issue.operandB),
        .ownBypass    (ownBypass),
        .memBypass    (memBypass),
        .resolvedValue(resolvedB)
    );

    // Store source register is the destination field
    operandBypass bypassStore (
        .lookupReg    (issue.writeReg),
        .suppliedValue(issue.storeData),
        .ownBypass    (ownBypass),
        .memBypass    (memBypass),
        .resolvedValue(resolvedStore)
    );

    //////////////////////////////
    // Execution units
    //////////////////////////////

    integerAlu alu (
        .aluOp      (issue.aluOp),
        .operandA   (resolvedA),
        .operandB   (resolvedB),
        .shiftAmount(issue.shiftAmount),
        .aluResult  (aluResult)
    );

    hiLoUnit hiLo (
        .CLK       (CLK),
        .RESET     (RESET),
        .FLUSH     (FLUSH),
        .aluOp     (issue.aluOp),
        .operandA  (resolvedA),
        .operandB  (resolvedB),
        .moveResult(moveResult)
    );

    // Move-from reads HI/LO, everything else takes the ALU
    assign isMoveFrom     = (issue.aluOp == exeIsaPkg::opMfhi)
                         || (issue.aluOp == exeIsaPkg::opMflo);
    assign combinedResult = isMoveFrom ? moveResult : aluResult;

    // Early bypass in the issue cycle
    always_comb begin
        earlyBypass.regNum = issue.writeReg;
        earlyBypass.data   = combinedResult;
        earlyBypass.valid  = issue.regWrite && !(issue.memRead || issue.memWrite);
    end

    //////////////////////////////
    // Stage register
    //////////////////////////////

    // Side-band fields are copied unchanged
    always_comb begin
        nextRetire.instr             = issue.instr;
        nextRetire.pc                = issue.pc;
        nextRetire.result            = combinedResult;
        nextRetire.writeReg          = issue.writeReg;
        nextRetire.storeData         = resolvedStore;
        nextRetire.regWrite          = issue.regWrite;
        nextRetire.memRead           = issue.memRead;
        nextRetire.memWrite          = issue.memWrite;
        nextRetire.aluOp             = issue.aluOp;
        nextRetire.branchPrediction  = issue.branchPrediction;
        nextRetire.branchPredictions = issue.branchPredictions;
        nextRetire.requestAltPc      = issue.requestAltPc;
        nextRetire.altPc             = issue.altPc;
    end

    // Flush turns the retiring slot into a bubble
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            retire <= '0;
        end else if (FLUSH) begin
            retire <= '0;
        end else begin
            retire <= nextRetire;
        end
    end

endmodule

//--- exeStage_checker.sv
module exeStage_checker (
    input logic                 CLK,
    input logic                 RESET,
    input logic                 FLUSH,
    input exePipePkg::exeIssue  issue,
    input exePipePkg::exeRetire retire,
    input exePipePkg::regBypass earlyBypass
);

    // Flush or reset leaves a bubble with all control bits low
    bubbleAfterClear: assert property (@(posedge CLK)
        (FLUSH || !RESET) |=> !(retire.regWrite || retire.memRead || retire.memWrite))
        else $error("Retire control bits set after flush or reset");

    // Only register-writing non-memory instructions are offered to decode
    earlyValidRule: assert property (@(posedge CLK) disable iff (!RESET)
        earlyBypass.valid == (issue.regWrite && !(issue.memRead || issue.memWrite)))
        else $error("Early bypass valid does not follow the issue control bits");

    // Redirect request reaches retire one edge later
    altPcCarried: assert property (@(posedge CLK) disable iff (!RESET)
        !FLUSH |=> (retire.requestAltPc == $past(issue.requestAltPc)
                    && retire.altPc == $past(issue.altPc)))
        else $error("Alternate PC request changed on its way to retire");

endmodule

bind exeStage exeStage_checker stageChecks (
    .CLK        (CLK),
    .RESET      (RESET),
    .FLUSH      (FLUSH),
    .issue      (issue),
    .retire     (retire),
    .earlyBypass(earlyBypass)
);

//--- exeStageTb.sv
module exeStageTb;

    // Reset, random and directed cycles plus a small margin
    localparam int cycleLimit = 2100;

    logic                 CLK;
    logic                 RESET;
    logic                 FLUSH;
    exePipePkg::exeIssue  issue;
    exePipePkg::regBypass memBypass;
    exePipePkg::exeRetire retire;
    exePipePkg::regBypass earlyBypass;

    // Model state
    // expRetire mirrors the retire register
    exePipePkg::exeRetire expRetire;
    logic [31:0]          modelHi;
    logic [31:0]          modelLo;
    logic [31:0]          rngState;
    int                   cycleCount;

    // Random code pool with an undefined code as the last entry
    logic [5:0] opTable [0:21] = '{exeIsaPkg::opAdd, exeIsaPkg::opSub, exeIsaPkg::opAnd,
        exeIsaPkg::opOr, exeIsaPkg::opXor, exeIsaPkg::opNor, exeIsaPkg::opSlt,
        exeIsaPkg::opSltu, exeIsaPkg::opSll, exeIsaPkg::opSrl, exeIsaPkg::opSra,
        exeIsaPkg::opSllv, exeIsaPkg::opSrlv, exeIsaPkg::opSrav, exeIsaPkg::opLui,
        exeIsaPkg::opMult, exeIsaPkg::opMultu, exeIsaPkg::opMthi, exeIsaPkg::opMtlo,
        exeIsaPkg::opMfhi, exeIsaPkg::opMflo, 6'h3f};

    // Directed HI/LO sequence
    logic [5:0] hiLoOps [0:9] = '{exeIsaPkg::opMult, exeIsaPkg::opMfhi, exeIsaPkg::opMflo,
        exeIsaPkg::opMultu, exeIsaPkg::opMfhi, exeIsaPkg::opMflo, exeIsaPkg::opMthi,
        exeIsaPkg::opMtlo, exeIsaPkg::opMfhi, exeIsaPkg::opMflo};

    exeStage uut (
        .CLK        (CLK),
        .RESET      (RESET),
        .FLUSH      (FLUSH),
        .issue      (issue),
        .memBypass  (memBypass),
        .retire     (retire),
        .earlyBypass(earlyBypass)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not end within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    //////////////////////////////
    // Random source and model
    //////////////////////////////

    function automatic logic [31:0] randomWord();
        logic [31:0] s;
        s = rngState;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rngState = s;
        return s;
    endfunction

    // Newest value of a register with the own result first and register zero never forwarded
    function automatic logic [31:0] forwardModel(input logic [4:0] regNum,
                                                 input logic [31:0] supplied);
        logic ownValid;
        ownValid = expRetire.regWrite && !expRetire.memRead && !expRetire.memWrite;
        if (regNum == 5'd0) return supplied;
        if (ownValid && expRetire.writeReg == regNum) return expRetire.result;
        if (memBypass.valid && memBypass.regNum == regNum) return memBypass.data;
        return supplied;
    endfunction

    function automatic logic [31:0] resultModel(input logic [5:0] op, input logic [31:0] a,
                                                input logic [31:0] b, input logic [4:0] sh);
        logic [63:0] wide;
        logic [4:0]  count;
        // Immediate shifts use the instruction field and variable ones use A
        count = (op == exeIsaPkg::opSll || op == exeIsaPkg::opSrl
                 || op == exeIsaPkg::opSra) ? sh : a[4:0];
        wide = {{32{b[31]}}, b} >> count;
        case (op)
            exeIsaPkg::opAdd: return a + b;
            exeIsaPkg::opSub: return a + ~b + 32'd1;
            exeIsaPkg::opAnd: return a & b;
            exeIsaPkg::opOr: return a | b;
            exeIsaPkg::opXor: return a ^ b;
            exeIsaPkg::opNor: return ~a & ~b;
            // When signs differ the negative one is smaller
            exeIsaPkg::opSlt: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            exeIsaPkg::opSltu: return {31'd0, a < b};
            exeIsaPkg::opSll, exeIsaPkg::opSllv: return b << count;
            exeIsaPkg::opSrl, exeIsaPkg::opSrlv: return b >> count;
            exeIsaPkg::opSra, exeIsaPkg::opSrav: return wide[31:0];
            exeIsaPkg::opLui: return {b[15:0], 16'h0000};
            exeIsaPkg::opMfhi: return modelHi;
            exeIsaPkg::opMflo: return modelLo;
            default: return 32'd0;
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Small retire fields packed into one word
    function automatic logic [31:0] controlWord(input exePipePkg::exeRetire r);
        return {14'd0, r.writeReg, r.regWrite, r.memRead, r.memWrite, r.aluOp,
                r.branchPrediction, r.branchPredictions, r.requestAltPc};
    endfunction

    //////////////////////////////
    // One pipeline cycle
    //////////////////////////////

    task automatic stepCycle(input exePipePkg::exeIssue nextIssue,
                             input exePipePkg::regBypass nextMem, input logic nextFlush);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] store;
        logic [31:0] res;
        logic [63:0] product;
        @(posedge CLK);
        issue     <= nextIssue;
        memBypass <= nextMem;
        FLUSH     <= nextFlush;
        // Sample away from the rising edge
        @(negedge CLK);
        checkValue("retire.result", retire.result, expRetire.result);
        checkValue("retire.storeData", retire.storeData, expRetire.storeData);
        checkValue("retire.instr", retire.instr, expRetire.instr);
        checkValue("retire.pc", retire.pc, expRetire.pc);
        checkValue("retire.altPc", retire.altPc, expRetire.altPc);
        checkValue("retire control", controlWord(retire), controlWord(expRetire));
        a     = forwardModel(nextIssue.regA, nextIssue.operandA);
        b     = forwardModel(nextIssue.regB, nextIssue.operandB);
        store = forwardModel(nextIssue.writeReg, nextIssue.storeData);
        res   = resultModel(nextIssue.aluOp, a, b, nextIssue.shiftAmount);
        checkValue("earlyBypass.data", earlyBypass.data, res);
        checkValue("earlyBypass tag", {26'd0, earlyBypass.regNum, earlyBypass.valid},
                   {26'd0, nextIssue.writeReg,
                    nextIssue.regWrite && !(nextIssue.memRead || nextIssue.memWrite)});
        // Flushed slot retires as a bubble and leaves HI/LO alone
        if (nextFlush) begin
            expRetire = '0;
        end else begin
            expRetire.instr             = nextIssue.instr;
            expRetire.pc                = nextIssue.pc;
            expRetire.result            = res;
            expRetire.writeReg          = nextIssue.writeReg;
            expRetire.storeData         = store;
            expRetire.regWrite          = nextIssue.regWrite;
            expRetire.memRead           = nextIssue.memRead;
            expRetire.memWrite          = nextIssue.memWrite;
            expRetire.aluOp             = nextIssue.aluOp;
            expRetire.branchPrediction  = nextIssue.branchPrediction;
            expRetire.branchPredictions = nextIssue.branchPredictions;
            expRetire.requestAltPc      = nextIssue.requestAltPc;
            expRetire.altPc             = nextIssue.altPc;
            // Sign extension before a 64-bit multiply gives the signed product
            if (nextIssue.aluOp == exeIsaPkg::opMult) begin
                product = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                {modelHi, modelLo} = product;
            end else if (nextIssue.aluOp == exeIsaPkg::opMultu) begin
                product = {32'd0, a} * {32'd0, b};
                {modelHi, modelLo} = product;
            end else if (nextIssue.aluOp == exeIsaPkg::opMthi) begin
                modelHi = a;
            end else if (nextIssue.aluOp == exeIsaPkg::opMtlo) begin
                modelLo = a;
            end
        end
    endtask

    //////////////////////////////
    // Stimulus builders
    //////////////////////////////

    function automatic exePipePkg::exeIssue makeIssue(input logic [5:0] op,
            input logic [4:0] ra, input logic [31:0] a, input logic [4:0] rb,
            input logic [31:0] b, input logic [4:0] wr);
        exePipePkg::exeIssue item;
        item          = '0;
        item.aluOp    = op;
        item.regA     = ra;
        item.operandA = a;
        item.regB     = rb;
        item.operandB = b;
        item.writeReg = wr;
        item.regWrite = 1'b1;
        return item;
    endfunction

    // Registers 0 to 3 only so forwarding hits often
    function automatic exePipePkg::exeIssue randomIssue();
        exePipePkg::exeIssue item;
        logic [31:0]         r;
        r    = randomWord();
        item = makeIssue(opTable[int'(r[31:24]) % 22], {3'd0, r[1:0]}, randomWord(),
                         {3'd0, r[3:2]}, randomWord(), {3'd0, r[5:4]});
        item.regWrite          = (r[8:6] != 3'd0);
        item.memRead           = (r[11:9] == 3'd0);
        item.memWrite          = (r[14:12] == 3'd0);
        item.shiftAmount       = r[19:15];
        item.branchPrediction  = r[20];
        item.branchPredictions = r[22:21];
        item.requestAltPc      = r[23];
        item.instr             = randomWord();
        item.pc                = randomWord();
        item.storeData         = randomWord();
        item.altPc             = randomWord();
        return item;
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        exePipePkg::exeIssue  d;
        exePipePkg::regBypass noMem;
        exePipePkg::regBypass m;
        logic [31:0]          r;
        CLK        = 1'b0;
        RESET      = 1'b0;
        FLUSH      = 1'b0;
        issue      = '0;
        memBypass  = '0;
        expRetire  = '0;
        modelHi    = '0;
        modelLo    = '0;
        rngState   = 32'h5f6961f7;
        cycleCount = 0;
        noMem      = '0;
        d          = '0;
        repeat (16) stepCycle(d, noMem, 1'b0);
        @(posedge CLK);
        RESET <= 1'b1;
        for (int i = 0; i < 2000; i++) begin
            r        = randomWord();
            m.valid  = r[0];
            m.regNum = {3'd0, r[2:1]};
            m.data   = randomWord();
            stepCycle(randomIssue(), m, r[7:3] == 5'd0);
        end
        // Both sources hold register 3 and the own result must win
        m = '{regNum: 5'd3, data: 32'h0bad0003, valid: 1'b1};
        stepCycle(makeIssue(exeIsaPkg::opAdd, 5'd1, 32'h10, 5'd2, 32'h20, 5'd3), noMem, 1'b0);
        stepCycle(makeIssue(exeIsaPkg::opSub, 5'd3, 32'h1, 5'd0, 32'h2, 5'd0), m, 1'b0);
        // Memory stage feeds A while the own result sits on register zero
        stepCycle(makeIssue(exeIsaPkg::opOr, 5'd3, 32'h1, 5'd0, 32'h5, 5'd2), m, 1'b0);
        // Store data comes from register 2
        d           = makeIssue(exeIsaPkg::opAdd, 5'd0, 32'h100, 5'd0, 32'h4, 5'd2);
        d.memWrite  = 1'b1;
        d.storeData = 32'h0000dead;
        stepCycle(d, noMem, 1'b0);
        // The store never feeds the own bypass even with regWrite set
        stepCycle(makeIssue(exeIsaPkg::opAdd, 5'd2, 32'h7, 5'd0, 32'h1, 5'd1), noMem, 1'b0);
        foreach (hiLoOps[k]) begin
            d = makeIssue(hiLoOps[k], 5'd0, randomWord(), 5'd0, randomWord(), 5'd6);
            stepCycle(d, noMem, 1'b0);
        end
        // Flushed move-to must not reach HI
        stepCycle(makeIssue(exeIsaPkg::opMthi, 5'd0, 32'h5a5a5a5a, 5'd0, 32'h0, 5'd6),
                  noMem, 1'b1);
        stepCycle(makeIssue(exeIsaPkg::opMfhi, 5'd0, 32'h0, 5'd0, 32'h0, 5'd6), noMem, 1'b0);
        d = '0;
        stepCycle(d, noMem, 1'b0);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- flist.f
exeIsaPkg.sv
exePipePkg.sv
operandBypass.sv
integerAlu.sv
hiLoUnit.sv
exeStage.sv
exeStage_checker.sv
exeStageTb.sv

//--- Makefile
TOP := exeStageTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f flist.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
